// ==== include/mx_macros.svh ====
`ifndef MX_MACROS_SVH
`define MX_MACROS_SVH

// sampling
`define MX_CLKS_PER_SAMPLE 4
`define MX_SAMPLES_PER_BIT 16
`define MX_SLICE_THRESH 14

// frame patterns, oldest bit in the msb
`define MX_PREAMBLE 8'b10101010
`define MX_SFD 8'b11010000
`define MX_PRE_THRESH 7
`define MX_SFD_THRESH 8

// timeouts in bit cells
`define MX_PRE_TIMEOUT_BITS 32
`define MX_SFD_TIMEOUT_BITS 16

`define MX_BYTE_W 8

`endif

// ==== hdl/mx_pkg.sv ====
`include "mx_macros.svh"

package mx_pkg;

  // receiver states
  typedef enum logic [3:0] {
    IDLE,
    PREAMBLE,
    SFD,
    RECEIVE,
    EOF
  } rx_state_t;

  typedef logic [`MX_BYTE_W-1:0] byte_t;

  // sample position inside a bit cell
  typedef logic [3:0] bit_phase_t;

  // agreement count, holds 0 to 8
  typedef logic [3:0] match_sum_t;

endpackage

// ==== hdl/slicer_if.sv ====
interface slicer_if;

  // strobe per sample, the flags are valid with it
  logic tick;
  logic one_cell;
  logic zero_cell;
  logic idle_cell;

  modport slicer (
    output tick,
    output one_cell,
    output zero_cell,
    output idle_cell
  );

  modport ctrl (
    input tick,
    input one_cell,
    input zero_cell,
    input idle_cell
  );

endinterface

// ==== hdl/sample_tick_gen.sv ====
`include "mx_macros.svh"

module sample_tick_gen (
  input  logic clk,
  input  logic rst,
  output logic tick
);

  localparam int DIV_W = $clog2(`MX_CLKS_PER_SAMPLE);

  logic [DIV_W-1:0] div_cnt;
  logic             wrap;

  assign wrap = (div_cnt == DIV_W'(`MX_CLKS_PER_SAMPLE - 1));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end
    else
    begin
      tick <= wrap;
      if (wrap)
        div_cnt <= '0;
      else
        div_cnt <= div_cnt + 1'b1;
    end
  end

  // one clk wide, never back to back
  assert property (@(posedge clk) disable iff (rst) tick |=> !tick);

endmodule

// ==== hdl/manchester_slicer.sv ====
`include "mx_macros.svh"

module manchester_slicer (
  input  logic     clk,
  input  logic     rst,
  input  logic     rxd,
  slicer_if.slicer sif,
  input  logic     tick
);

  localparam int N     = `MX_SAMPLES_PER_BIT;
  localparam int CNT_W = $clog2(N + 1);
  // high then low, oldest sample in the msb
  localparam logic [N-1:0] ONE_TMPL = {{(N / 2){1'b1}}, {(N / 2){1'b0}}};

  logic [N-1:0]     window;
  logic [N-1:0]     window_next;
  logic [CNT_W-1:0] one_agree;
  logic [CNT_W-1:0] zero_agree;

  // window including the sample of this tick
  assign window_next = {window[N-2:0], rxd};

  // the zero template is the inverse, so its count is the complement
  always_comb
  begin
    one_agree = '0;
    for (int i = 0; i < N; i++)
      one_agree = one_agree + CNT_W'(window_next[i] == ONE_TMPL[i]);
    zero_agree = CNT_W'(N) - one_agree;
  end

  ///////////////////////////////////////////////////
  // window and registered cell flags
  ///////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      window        <= '1;
      sif.tick      <= 1'b0;
      sif.one_cell  <= 1'b0;
      sif.zero_cell <= 1'b0;
      sif.idle_cell <= 1'b0;
    end
    else
    begin
      sif.tick <= tick;
      if (tick)
      begin
        window        <= window_next;
        sif.one_cell  <= (one_agree >= CNT_W'(`MX_SLICE_THRESH));
        sif.zero_cell <= (zero_agree >= CNT_W'(`MX_SLICE_THRESH));
        sif.idle_cell <= &window_next;
      end
    end
  end

  // threshold above half, a cell cannot lean both ways
  assert property (@(posedge clk) disable iff (rst) !(sif.one_cell && sif.zero_cell));

endmodule

// ==== hdl/pattern_correlator.sv ====
`include "mx_macros.svh"

module pattern_correlator #(
  parameter logic [7:0] PATTERN = `MX_PREAMBLE,
  parameter int         THRESH  = `MX_PRE_THRESH
) (
  input  logic clk,
  input  logic rst,
  input  logic clear,
  input  logic bit_valid,
  input  logic bit_value,
  output logic match
);

  import mx_pkg::*;

  localparam int LEN = $bits(PATTERN);

  logic [LEN-1:0] history;
  // marks history slots that hold a bit since the last clear
  logic [LEN-1:0] filled;
  match_sum_t     agree;

  always_ff @(posedge clk)
  begin
    if (bit_valid)
      history <= {history[LEN-2:0], bit_value};
  end

  always_ff @(posedge clk)
  begin
    if (rst || clear)
      filled <= '0;
    else if (bit_valid)
      filled <= {filled[LEN-2:0], 1'b1};
  end

  always_comb
  begin
    agree = '0;
    for (int i = 0; i < LEN; i++)
      agree = agree + match_sum_t'(history[i] == PATTERN[i]);
  end

  assign match = (&filled) && (agree >= match_sum_t'(THRESH));

endmodule

// ==== hdl/frame_controller.sv ====
`include "mx_macros.svh"

module frame_controller (
  input  logic          clk,
  input  logic          rst,
  slicer_if.ctrl        sif,
  input  logic          pre_match,
  input  logic          sfd_match,
  output logic          bit_valid,
  output logic          bit_value,
  output logic          corr_clear,
  output mx_pkg::byte_t data,
  output logic          write,
  output logic          cardet,
  output logic          error
);

  import mx_pkg::*;

  // first flag from a high line comes early by the threshold slack,
  // so the phase starts late enough to decide on the cell centre
  localparam bit_phase_t LOCK_PHASE = bit_phase_t'(`MX_SLICE_THRESH);
  localparam bit_phase_t LAST_PHASE = bit_phase_t'(`MX_SAMPLES_PER_BIT - 1);
  localparam int         CELL_W     = $clog2(`MX_PRE_TIMEOUT_BITS + 1);
  localparam int         BIT_W      = $clog2(`MX_BYTE_W);

  rx_state_t         state;
  bit_phase_t        phase;
  logic [CELL_W-1:0] cell_cnt;
  logic [BIT_W-1:0]  bit_cnt;
  byte_t             shreg;
  byte_t             byte_next;
  logic              got_byte;
  logic              lock;
  logic              decide;
  logic              decided;

  assign lock    = (state == IDLE) && sif.tick && (sif.one_cell || sif.zero_cell);
  assign decide  = (state != IDLE) && sif.tick && (phase == LAST_PHASE);
  assign decided = sif.one_cell || sif.zero_cell;

  assign bit_valid  = decide && decided;
  assign bit_value  = sif.one_cell;
  assign corr_clear = lock;

  // lsb first, new bit enters at the top
  assign byte_next = {sif.one_cell, shreg[`MX_BYTE_W-1:1]};

  always_ff @(posedge clk)
  begin
    if (rst)
      phase <= '0;
    else if (lock)
      phase <= LOCK_PHASE;
    else if (sif.tick)
      phase <= phase + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (state == RECEIVE && bit_valid)
      shreg <= byte_next;
  end

  ///////////////////////////////////////////////////
  // frame fsm
  ///////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= IDLE;
      cell_cnt <= '0;
      bit_cnt  <= '0;
      got_byte <= 1'b0;
      data     <= '0;
      write    <= 1'b0;
      cardet   <= 1'b0;
      error    <= 1'b0;
    end
    else
    begin
      write <= 1'b0;
      case (state)
        IDLE:
        begin
          if (lock)
          begin
            state    <= PREAMBLE;
            cell_cnt <= '0;
          end
        end
        PREAMBLE:
        begin
          if (pre_match)
          begin
            state    <= SFD;
            cell_cnt <= '0;
            cardet   <= 1'b1;
            error    <= 1'b0;
          end
          else if (decide)
          begin
            // no carrier, drop back without a flag
            if (cell_cnt == CELL_W'(`MX_PRE_TIMEOUT_BITS))
              state <= IDLE;
            else
              cell_cnt <= cell_cnt + 1'b1;
          end
        end
        SFD:
        begin
          if (sfd_match)
          begin
            state    <= RECEIVE;
            bit_cnt  <= '0;
            got_byte <= 1'b0;
          end
          else if (decide)
          begin
            if (cell_cnt == CELL_W'(`MX_SFD_TIMEOUT_BITS))
            begin
              state  <= IDLE;
              cardet <= 1'b0;
              error  <= 1'b1;
            end
            else
              cell_cnt <= cell_cnt + 1'b1;
          end
        end
        RECEIVE:
        begin
          if (decide)
          begin
            if (decided)
            begin
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == BIT_W'(`MX_BYTE_W - 1))
              begin
                data     <= byte_next;
                write    <= 1'b1;
                got_byte <= 1'b1;
              end
            end
            // first idle cell of the end marker
            else if (sif.idle_cell && bit_cnt == '0 && got_byte)
              state <= EOF;
            else
            begin
              state  <= IDLE;
              cardet <= 1'b0;
              error  <= 1'b1;
            end
          end
        end
        EOF:
        begin
          if (decide)
          begin
            state  <= IDLE;
            cardet <= 1'b0;
            error  <= !sif.idle_cell;
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // bytes only leave while a frame body is being received
  assert property (@(posedge clk) disable iff (rst) write |-> state == RECEIVE);

endmodule

// ==== hdl/mx_rcvr.sv ====
`include "mx_macros.svh"

module mx_rcvr (
  input  logic          clk,
  input  logic          rst,
  input  logic          rxd,
  output mx_pkg::byte_t data,
  output logic          write,
  output logic          cardet,
  output logic          error
);

  logic tick;
  logic pre_match;
  logic sfd_match;
  logic bit_valid;
  logic bit_value;
  logic corr_clear;

  slicer_if sif ();

  sample_tick_gen u_tick_gen (
    .clk  (clk),
    .rst  (rst),
    .tick (tick)
  );

  manchester_slicer u_slicer (
    .clk  (clk),
    .rst  (rst),
    .rxd  (rxd),
    .sif  (sif.slicer),
    .tick (tick)
  );

  pattern_correlator #(
    .PATTERN (`MX_PREAMBLE),
    .THRESH  (`MX_PRE_THRESH)
  ) u_pre_corr (
    .clk       (clk),
    .rst       (rst),
    .clear     (corr_clear),
    .bit_valid (bit_valid),
    .bit_value (bit_value),
    .match     (pre_match)
  );

  pattern_correlator #(
    .PATTERN (`MX_SFD),
    .THRESH  (`MX_SFD_THRESH)
  ) u_sfd_corr (
    .clk       (clk),
    .rst       (rst),
    .clear     (corr_clear),
    .bit_valid (bit_valid),
    .bit_value (bit_value),
    .match     (sfd_match)
  );

  frame_controller u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .sif        (sif.ctrl),
    .pre_match  (pre_match),
    .sfd_match  (sfd_match),
    .bit_valid  (bit_valid),
    .bit_value  (bit_value),
    .corr_clear (corr_clear),
    .data       (data),
    .write      (write),
    .cardet     (cardet),
    .error      (error)
  );

endmodule

// ==== tests/tb_mx_rcvr.sv ====
`include "mx_macros.svh"

module tb_mx_rcvr;

  import mx_pkg::*;

  localparam int HALF_CLKS   = `MX_SAMPLES_PER_BIT / 2 * `MX_CLKS_PER_SAMPLE;
  localparam int CELL_CLKS   = 2 * HALF_CLKS;
  // long enough for a stray lock to time out before the next preamble
  localparam int LEAD_CELLS  = `MX_PRE_TIMEOUT_BITS + 8;
  localparam int QUIET_CELLS = `MX_PRE_TIMEOUT_BITS + 16;
  localparam int WAIT_CLKS   = 4 * CELL_CLKS;

  logic   clk;
  logic   rst;
  logic   rxd;
  byte_t  data;
  logic   write;
  logic   cardet;
  logic   error;

  integer seed;
  string  test_name;
  byte_t  exp_q[$];
  byte_t  exp_head = '0;
  int     exp_count = 0;
  byte_t  frame_bytes[8];
  logic   pre_sent;
  logic   clean_frame;
  logic   quiet;

  mx_rcvr i_dut (
    .clk    (clk),
    .rst    (rst),
    .rxd    (rxd),
    .data   (data),
    .write  (write),
    .cardet (cardet),
    .error  (error)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  task automatic abort_run();
    begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at the first failing check");
    end
  endtask

  // the checks see the new head one clk after each pop
  always @(posedge clk)
  begin
    if (write && exp_q.size() > 0)
      void'(exp_q.pop_front());
    exp_count <= exp_q.size();
    if (exp_q.size() > 0)
      exp_head <= exp_q[0];
    else
      exp_head <= '0;
  end

  ///////////////////////////////////////////////////
  // checks
  ///////////////////////////////////////////////////

  no_output_before_preamble: assert property (@(posedge clk) disable iff (rst)
    !pre_sent |-> !cardet && !write && !error)
  else
  begin
    $display("Mismatch %s: expected cardet/write/error 000, actual %b%b%b", test_name,
             $sampled(cardet), $sampled(write), $sampled(error));
    abort_run();
  end

  write_expected: assert property (@(posedge clk) disable iff (rst)
    write |-> exp_count > 0)
  else
  begin
    $display("unexpected write of %02h in %s, no byte was pending", $sampled(data),
             test_name);
    abort_run();
  end

  data_matches: assert property (@(posedge clk) disable iff (rst)
    write && exp_count > 0 |-> data == exp_head)
  else
  begin
    $display("Mismatch %s: expected data %02h, actual %02h", test_name,
             $sampled(exp_head), $sampled(data));
    abort_run();
  end

  write_under_carrier: assert property (@(posedge clk) disable iff (rst)
    write |-> cardet)
  else
  begin
    $display("write seen while cardet was low in %s", test_name);
    abort_run();
  end

  // error may still be set from an earlier frame until cardet rises
  clean_without_error: assert property (@(posedge clk) disable iff (rst)
    clean_frame && (cardet || $fell(cardet)) |-> !error)
  else
  begin
    $display("Mismatch %s: expected error 0, actual 1", test_name);
    abort_run();
  end

  quiet_line_no_carrier: assert property (@(posedge clk) disable iff (rst)
    quiet |-> !cardet)
  else
  begin
    $display("Mismatch %s: expected cardet 0, actual 1", test_name);
    abort_run();
  end

  ///////////////////////////////////////////////////
  // line driver
  ///////////////////////////////////////////////////

  task automatic drive_half(input logic level);
    repeat (HALF_CLKS)
    begin
      @(posedge clk);
      rxd <= level;
    end
  endtask

  // a 1 is high then low and a 0 is low then high
  task automatic send_bit(input logic b);
    begin
      drive_half(b);
      drive_half(!b);
    end
  endtask

  task automatic send_idle(input int cells);
    repeat (cells)
    begin
      drive_half(1'b1);
      drive_half(1'b1);
    end
  endtask

  // oldest bit in the msb
  task automatic send_pattern(input byte_t p);
    for (int i = 7; i >= 0; i--)
      send_bit(p[i]);
  endtask

  task automatic send_bits_lsb_first(input byte_t b, input int count);
    for (int k = 0; k < count; k++)
      send_bit(b[k]);
  endtask

  // first half always high so decided bits never mix ones and zeros
  task automatic send_random_cells(input int cells);
    int r;
    begin
      repeat (cells)
      begin
        r = $random(seed);
        drive_half(1'b1);
        drive_half(r[0]);
      end
    end
  endtask

  // cut_byte below zero sends the whole frame
  task automatic send_frame(input int n_bytes, input byte_t sfd, input int cut_byte);
    int   r;
    logic cut;
    begin
      cut = 1'b0;
      for (int i = 0; i < n_bytes; i++)
      begin
        r = $random(seed);
        frame_bytes[i] = byte_t'(r);
        if (cut_byte < 0 || i < cut_byte)
          exp_q.push_back(frame_bytes[i]);
      end
      send_idle(LEAD_CELLS);
      pre_sent <= 1'b1;
      send_pattern(`MX_PREAMBLE);
      send_pattern(`MX_PREAMBLE);
      send_pattern(sfd);
      for (int i = 0; i < n_bytes && !cut; i++)
      begin
        if (i == cut_byte)
        begin
          send_bits_lsb_first(frame_bytes[i], 4);
          cut = 1'b1;
        end
        else
          send_bits_lsb_first(frame_bytes[i], 8);
      end
      if (cut)
      begin
        // flat low cell that is neither a 1 nor a 0
        drive_half(1'b0);
        drive_half(1'b0);
        send_idle(1);
      end
      else
        send_idle(3);
    end
  endtask

  ///////////////////////////////////////////////////
  // waits and frame checks
  ///////////////////////////////////////////////////

  task automatic wait_cardet_low();
    int n;
    begin
      n = 0;
      while (cardet && n < WAIT_CLKS)
      begin
        @(posedge clk);
        n++;
      end
      if (cardet)
      begin
        $display("cardet did not fall within %0d clocks in %s", WAIT_CLKS, test_name);
        abort_run();
      end
    end
  endtask

  task automatic wait_error_flag();
    int n;
    begin
      n = 0;
      while (!(error && !cardet) && n < WAIT_CLKS)
      begin
        @(posedge clk);
        n++;
      end
      if (!(error && !cardet))
      begin
        $display("error did not rise with cardet low within %0d clocks in %s",
                 WAIT_CLKS, test_name);
        abort_run();
      end
    end
  endtask

  task automatic check_queue_empty();
    assert (exp_q.size() == 0)
    else
    begin
      $display("Mismatch %s: expected 0 bytes pending, actual %0d", test_name, exp_q.size());
      abort_run();
    end
  endtask

  task automatic run_clean_frame(input int n_bytes);
    begin
      clean_frame <= 1'b1;
      send_frame(n_bytes, `MX_SFD, -1);
      wait_cardet_low();
      clean_frame <= 1'b0;
      check_queue_empty();
    end
  endtask

  initial
  begin
    int r;
    seed        = 32'hb6c8545c;
    rst         = 1'b1;
    rxd         = 1'b1;
    pre_sent    = 1'b0;
    clean_frame = 1'b0;
    quiet       = 1'b0;
    test_name   = "reset_idle";
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    send_idle(8);

    for (int f = 0; f < 3; f++)
    begin
      test_name = $sformatf("clean_frame_%0d", f);
      r = $random(seed);
      run_clean_frame(1 + (r & 3));
    end

    test_name = "mid_byte_error";
    send_frame(3, `MX_SFD, 1);
    wait_error_flag();
    check_queue_empty();

    test_name = "recovery_frame";
    run_clean_frame(2);

    test_name = "bad_sfd";
    send_frame(0, 8'b11010100, -1);
    wait_error_flag();
    check_queue_empty();

    test_name = "idle_line";
    quiet <= 1'b1;
    send_idle(QUIET_CELLS);
    test_name = "random_cells";
    send_random_cells(QUIET_CELLS);
    quiet <= 1'b0;

    test_name = "final_frame";
    r = $random(seed);
    run_clean_frame(1 + (r & 3));

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== mx_rcvr.f ====
+incdir+include
hdl/mx_pkg.sv
hdl/slicer_if.sv
hdl/sample_tick_gen.sv
hdl/manchester_slicer.sv
hdl/pattern_correlator.sv
hdl/frame_controller.sv
hdl/mx_rcvr.sv
tests/tb_mx_rcvr.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mx_rcvr
FILELIST  = mx_rcvr.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
